/* Makefile */
# Verilator build and run of the PUSCH DR testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pusch_dr -f files.f
	./obj_dir/Vtb_pusch_dr | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* files.f */
logic/dr_pkg.sv
logic/rbg_frame_if.sv
logic/rbg_framer.sv
logic/beam_power_accum.sv
logic/rbg_sample_buffer.sv
logic/beam_select.sv
logic/pusch_dr_top.sv
verif/pusch_dr_sva.sv
verif/tb_pusch_dr.sv

/* logic/beam_power_accum.sv */
/*
 * Beam power accumulator.
 * Sums I^2 + Q^2 of every beam over the REs of one RBG and
 * presents the totals with a one-cycle valid pulse after eop.
 */
`timescale 1ns/10ps

module beam_power_accum import dr_pkg::*; #(
    parameter int NUM_BEAM = dr_pkg::NUM_BEAM
) (
    input  logic                i_clk,
    input  logic                i_reset,
    rbg_frame_if.sink           frm,
    output logic                o_pwr_vld,
    output pwr_t [NUM_BEAM-1:0] o_pwr
);

    pwr_t [NUM_BEAM-1:0] acc;
    pwr_t [NUM_BEAM-1:0] acc_next;

    // power of one complex sample, always non-negative
    function automatic pwr_t re_power(input sample_t s);
        logic signed [SAMPLE_W/2-1:0] si;
        logic signed [SAMPLE_W/2-1:0] sq;
        logic signed [SAMPLE_W-1:0]   pi;
        logic signed [SAMPLE_W-1:0]   pq;
        si = s[SAMPLE_W-1 -: SAMPLE_W/2];
        sq = s[SAMPLE_W/2-1:0];
        pi = si * si;
        pq = sq * sq;
        return pwr_t'($unsigned(pi)) + pwr_t'($unsigned(pq));
    endfunction

    // sop reloads instead of adding, no clear cycle between RBGs
    always_comb begin
        for (int b = 0; b < NUM_BEAM; b++) begin
            acc_next[b] = (frm.sop ? '0 : acc[b]) + re_power(frm.samples[b]);
        end
    end

    always_ff @(posedge i_clk) begin
        if (frm.vld) begin
            acc <= acc_next;
        end
        if (frm.vld && frm.eop) begin
            o_pwr <= acc_next;   // totals include the eop RE
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pwr_vld <= 1'b0;
        end else begin
            o_pwr_vld <= frm.vld && frm.eop;
        end
    end

endmodule

/* logic/beam_select.sv */
/*
 * Beam selector.
 * Ranks the beams by RBG power when the totals arrive, keeps the
 * index and power of the NUM_PICK strongest, and outputs those
 * beams from every replayed RE in rank order. Ties go to the
 * lower beam index.
 */
`timescale 1ns/10ps

module beam_select import dr_pkg::*; #(
    parameter int NUM_BEAM = dr_pkg::NUM_BEAM,
    parameter int NUM_PICK = dr_pkg::NUM_PICK
) (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_pwr_vld,
    input  pwr_t [NUM_BEAM-1:0]      i_pwr,
    rbg_frame_if.sink                rply,
    output logic                     o_dr_vld,
    output logic                     o_dr_sop,
    output logic                     o_dr_eop,
    output logic [RBG_IDX_W-1:0]     o_rbg_idx,
    output sample_t [NUM_PICK-1:0]   o_dr_data,
    output beam_idx_t [NUM_PICK-1:0] o_beam_idx,
    output pwr_t [NUM_PICK-1:0]      o_beam_pwr
);

    localparam int IDX_W = $clog2(NUM_BEAM);

    logic [IDX_W-1:0]          rank [NUM_BEAM];
    beam_idx_t [NUM_PICK-1:0]  pick_idx;
    pwr_t [NUM_PICK-1:0]       pick_pwr;
    beam_idx_t [NUM_PICK-1:0]  sel_idx;    // ranked list of the current RBG
    pwr_t [NUM_PICK-1:0]       sel_pwr;

    // ------------------------------------------------------------------------
    // rank = beams stronger + equal beams with a lower index
    // ------------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < NUM_BEAM; b++) begin
            rank[b] = '0;
            for (int j = 0; j < NUM_BEAM; j++) begin
                if ((i_pwr[j] > i_pwr[b]) || ((i_pwr[j] == i_pwr[b]) && (j < b))) begin
                    rank[b] = rank[b] + 1'b1;
                end
            end
        end
    end

    // ranks are unique, so exactly one beam lands in each slot
    always_comb begin
        for (int k = 0; k < NUM_PICK; k++) begin
            pick_idx[k] = '0;
            pick_pwr[k] = '0;
            for (int b = 0; b < NUM_BEAM; b++) begin
                if (rank[b] == IDX_W'(k)) begin
                    pick_idx[k] = beam_idx_t'(b);
                    pick_pwr[k] = i_pwr[b];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_pwr_vld) begin
            sel_idx <= pick_idx;
            sel_pwr <= pick_pwr;
        end
    end

    // ------------------------------------------------------------------------
    // output stage, one register per replayed RE
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_dr_vld <= 1'b0;
            o_dr_sop <= 1'b0;
            o_dr_eop <= 1'b0;
        end else begin
            o_dr_vld <= rply.vld;
            o_dr_sop <= rply.vld && rply.sop;
            o_dr_eop <= rply.vld && rply.eop;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rply.vld) begin
            for (int k = 0; k < NUM_PICK; k++) begin
                o_dr_data[k] <= rply.samples[sel_idx[k]];   // slot 0 strongest
            end
            o_beam_idx <= sel_idx;     // held with the RE, next list may load meanwhile
            o_beam_pwr <= sel_pwr;
            o_rbg_idx  <= rply.rbg_idx;
        end
    end

endmodule

/* logic/dr_pkg.sv */
/*
 * Beam-domain dimension reduction, shared definitions.
 * Sizes, widths, payload types and the RBG size-code decoding
 * used across the PUSCH DR datapath.
 */
package dr_pkg;

    parameter int NUM_BEAM   = 8;    // beams per RE at the input
    parameter int NUM_PICK   = 4;    // strongest beams kept per RBG
    parameter int SAMPLE_W   = 32;   // {I[15:0], Q[15:0]}
    parameter int PWR_W      = 40;   // RBG power accumulator width
    parameter int RE_CNT_W   = 6;    // holds an RBG length up to 48
    parameter int RBG_IDX_W  = 4;    // RBG index within a symbol
    parameter int MAX_RBG_RE = 48;   // longest RBG, depth of one buffer bank

    typedef logic [$clog2(NUM_BEAM)-1:0] beam_idx_t;
    typedef logic [SAMPLE_W-1:0]         sample_t;
    typedef logic [PWR_W-1:0]            pwr_t;

    // RBG length in REs for a size code
    function automatic logic [RE_CNT_W-1:0] rbg_len(input logic [1:0] code);
        logic [RE_CNT_W-1:0] len;
        case (code)
            2'd0:    len = RE_CNT_W'(12);
            2'd1:    len = RE_CNT_W'(24);
            default: len = RE_CNT_W'(MAX_RBG_RE);   // codes 2 and 3
        endcase
        return len;
    endfunction

endpackage

/* logic/pusch_dr_top.sv */
/*
 * PUSCH DR top level.
 * Framer feeds the power accumulator and the sample buffer in
 * parallel; the selector ranks the beams and outputs the strongest
 * NUM_PICK of every replayed RE. Latency is RBG length + 4 cycles.
 */
`timescale 1ns/10ps

module pusch_dr_top import dr_pkg::*; #(
    parameter int NUM_BEAM = dr_pkg::NUM_BEAM,
    parameter int NUM_PICK = dr_pkg::NUM_PICK
) (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_vld,
    input  logic                     i_sop,
    input  logic                     i_eop,
    input  logic [1:0]               i_rbg_size,
    input  sample_t [NUM_BEAM-1:0]   i_samples,
    output logic                     o_dr_vld,
    output logic                     o_dr_sop,
    output logic                     o_dr_eop,
    output logic [RBG_IDX_W-1:0]     o_rbg_idx,
    output sample_t [NUM_PICK-1:0]   o_dr_data,
    output beam_idx_t [NUM_PICK-1:0] o_beam_idx,
    output pwr_t [NUM_PICK-1:0]      o_beam_pwr
);

    logic                pwr_vld;
    pwr_t [NUM_BEAM-1:0] pwr;

    rbg_frame_if #(.NUM_BEAM(NUM_BEAM)) frm ();    // framed input REs
    rbg_frame_if #(.NUM_BEAM(NUM_BEAM)) rply ();   // replayed RBG

    // ------------------------------------------------------------------------
    // framing, then power and buffering side by side
    // ------------------------------------------------------------------------
    rbg_framer #(.NUM_BEAM(NUM_BEAM)) u_framer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_vld      (i_vld),
        .i_sop      (i_sop),
        .i_eop      (i_eop),
        .i_rbg_size (i_rbg_size),
        .i_samples  (i_samples),
        .frm        (frm)
    );

    beam_power_accum #(.NUM_BEAM(NUM_BEAM)) u_accum (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .frm       (frm),
        .o_pwr_vld (pwr_vld),
        .o_pwr     (pwr)
    );

    rbg_sample_buffer #(.NUM_BEAM(NUM_BEAM)) u_buffer (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .frm     (frm),
        .rply    (rply)
    );

    beam_select #(.NUM_BEAM(NUM_BEAM), .NUM_PICK(NUM_PICK)) u_select (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_pwr_vld  (pwr_vld),
        .i_pwr      (pwr),
        .rply       (rply),
        .o_dr_vld   (o_dr_vld),
        .o_dr_sop   (o_dr_sop),
        .o_dr_eop   (o_dr_eop),
        .o_rbg_idx  (o_rbg_idx),
        .o_dr_data  (o_dr_data),
        .o_beam_idx (o_beam_idx),
        .o_beam_pwr (o_beam_pwr)
    );

endmodule

/* logic/rbg_frame_if.sv */
/*
 * RBG frame interface.
 * One RE of beam samples per cycle with RBG framing strobes
 * and the RBG index within the symbol.
 */
`timescale 1ns/10ps

interface rbg_frame_if import dr_pkg::*; #(
    parameter int NUM_BEAM = dr_pkg::NUM_BEAM
) ();

    logic                          vld;
    logic                          sop;       // first RE of the RBG
    logic                          eop;       // last RE of the RBG
    logic [RBG_IDX_W-1:0]          rbg_idx;
    sample_t [NUM_BEAM-1:0]        samples;   // one complex sample per beam

    modport source (output vld, sop, eop, rbg_idx, samples);
    modport sink   (input  vld, sop, eop, rbg_idx, samples);

endinterface

/* logic/rbg_framer.sv */
/*
 * RBG framer.
 * Registers the input REs, counts REs against the RBG length taken
 * from the size code at symbol start, and marks sop/eop of every RBG.
 * i_eop closes a short last RBG early.
 */
`timescale 1ns/10ps

module rbg_framer import dr_pkg::*; #(
    parameter int NUM_BEAM = dr_pkg::NUM_BEAM
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_vld,
    input  logic                   i_sop,       // first RE of a symbol
    input  logic                   i_eop,       // last RE of a symbol
    input  logic [1:0]             i_rbg_size,
    input  sample_t [NUM_BEAM-1:0] i_samples,
    rbg_frame_if.source            frm
);

    logic [RE_CNT_W-1:0]  re_cnt;
    logic [RE_CNT_W-1:0]  rbg_len_q;     // length latched at symbol start
    logic [RBG_IDX_W-1:0] rbg_idx_q;
    logic [RE_CNT_W-1:0]  cur_len;
    logic [RE_CNT_W-1:0]  cur_cnt;
    logic [RBG_IDX_W-1:0] cur_idx;
    logic                 last_re;

    // a new symbol restarts length, RE count and RBG index in the same cycle
    always_comb begin
        cur_len = i_sop ? rbg_len(i_rbg_size) : rbg_len_q;
        cur_cnt = i_sop ? '0 : re_cnt;
        cur_idx = i_sop ? '0 : rbg_idx_q;
        last_re = i_eop || (cur_cnt == cur_len - 1'b1);
    end

    // ------------------------------------------------------------------------
    // counters and framing strobes
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt    <= '0;
            rbg_len_q <= rbg_len(2'd2);
            rbg_idx_q <= '0;
            frm.vld   <= 1'b0;
            frm.sop   <= 1'b0;
            frm.eop   <= 1'b0;
        end else begin
            frm.vld <= i_vld;
            frm.sop <= i_vld && (cur_cnt == '0);
            frm.eop <= i_vld && last_re;
            if (i_vld) begin
                rbg_len_q <= cur_len;
                re_cnt    <= last_re ? '0 : cur_cnt + 1'b1;
                rbg_idx_q <= last_re ? cur_idx + 1'b1 : cur_idx;   // next RBG
            end
        end
    end

    // payload register
    always_ff @(posedge i_clk) begin
        if (i_vld) begin
            frm.rbg_idx <= cur_idx;
            frm.samples <= i_samples;
        end
    end

endmodule

/* logic/rbg_sample_buffer.sv */
/*
 * RBG sample buffer.
 * Two banks of MAX_RBG_RE entries used ping-pong. One bank fills
 * while the other replays its completed RBG, one RE per cycle,
 * with its own framing and RBG index. Read latency is one cycle.
 */
`timescale 1ns/10ps

module rbg_sample_buffer import dr_pkg::*; #(
    parameter int NUM_BEAM = dr_pkg::NUM_BEAM
) (
    input  logic        i_clk,
    input  logic        i_reset,
    rbg_frame_if.sink   frm,
    rbg_frame_if.source rply
);

    sample_t [NUM_BEAM-1:0] mem [2][MAX_RBG_RE];
    logic [RE_CNT_W-1:0]    bank_len [2];   // stored RBG length per bank
    logic [RBG_IDX_W-1:0]   bank_idx [2];

    logic                   wr_bank;
    logic [RE_CNT_W-1:0]    wr_cnt;
    logic [RE_CNT_W-1:0]    wr_addr;
    logic                   rd_active;
    logic                   rd_bank;
    logic [RE_CNT_W-1:0]    rd_addr;
    logic                   rd_last;

    assign wr_addr = frm.sop ? '0 : wr_cnt;
    assign rd_last = (rd_addr == bank_len[rd_bank] - 1'b1);

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (frm.vld) begin
            mem[wr_bank][wr_addr] <= frm.samples;
            if (frm.eop) begin
                bank_len[wr_bank] <= wr_addr + 1'b1;
                bank_idx[wr_bank] <= frm.rbg_idx;
            end
        end
    end

    // ------------------------------------------------------------------------
    // bank control and replay counter
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_bank   <= 1'b0;
            wr_cnt    <= '0;
            rd_active <= 1'b0;
            rd_bank   <= 1'b0;
            rd_addr   <= '0;
            rply.vld  <= 1'b0;
            rply.sop  <= 1'b0;
            rply.eop  <= 1'b0;
        end else begin
            if (frm.vld) begin
                wr_cnt <= frm.eop ? '0 : wr_addr + 1'b1;
                if (frm.eop) wr_bank <= ~wr_bank;    // swap banks
            end
            if (frm.vld && frm.eop) begin            // completed bank starts replay
                rd_active <= 1'b1;
                rd_bank   <= wr_bank;
                rd_addr   <= '0;
            end else if (rd_active) begin
                rd_addr <= rd_addr + 1'b1;
                if (rd_last) rd_active <= 1'b0;
            end
            rply.vld <= rd_active;
            rply.sop <= rd_active && (rd_addr == '0);
            rply.eop <= rd_active && rd_last;
        end
    end

    // read data, registered with the strobes
    always_ff @(posedge i_clk) begin
        if (rd_active) begin
            rply.samples <= mem[rd_bank][rd_addr];
            rply.rbg_idx <= bank_idx[rd_bank];
        end
    end

endmodule

/* verif/pusch_dr_sva.sv */
/*
 * PUSCH DR protocol assertions.
 * Bound to the top level. Checks quiet outputs after reset,
 * output framing, unique beam lists and the RBG output latency.
 */
`timescale 1ns/10ps

module pusch_dr_sva import dr_pkg::*; #(
    parameter int NUM_PICK = dr_pkg::NUM_PICK
) (
    input logic                     i_clk,
    input logic                     i_reset,
    input logic                     i_vld,
    input logic                     i_pwr_vld,    // RBG totals, two cycles after last input RE
    input logic                     i_dr_vld,
    input logic                     i_dr_sop,
    input logic                     i_dr_eop,
    input beam_idx_t [NUM_PICK-1:0] i_beam_idx
);

    logic seen_in;   // any input RE since reset

    function automatic logic idx_unique(input beam_idx_t [NUM_PICK-1:0] idx);
        logic ok;
        ok = 1'b1;
        for (int a = 0; a < NUM_PICK; a++) begin
            for (int c = a + 1; c < NUM_PICK; c++) begin
                if (idx[a] == idx[c]) ok = 1'b0;
            end
        end
        return ok;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) seen_in <= 1'b0;
        else if (i_vld) seen_in <= 1'b1;
    end

    // ------------------------------------------------------------------------
    // output protocol
    // ------------------------------------------------------------------------
    a_quiet: assert property (@(posedge i_clk) disable iff (i_reset)
        !seen_in |-> (!i_dr_vld && !i_dr_sop && !i_dr_eop))
        else $error("output strobe active before any input RE");
    // a valid RE right after the last RE of an RBG opens the next RBG
    a_next_rbg: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dr_eop |=> (!i_dr_vld || i_dr_sop))
        else $error("output RBG continues past its eop");
    a_unique: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dr_vld |-> idx_unique(i_beam_idx))
        else $error("beam index listed twice");
    // sop lands 4 cycles after the last input RE of the RBG
    a_latency: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pwr_vld |-> ##2 i_dr_sop)
        else $error("first output RE of an RBG is late");
    a_no_stray_sop: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dr_sop |-> $past(i_pwr_vld, 2))
        else $error("output sop without a completed RBG");

endmodule

/* verif/tb_pusch_dr.sv */
/*
 * Testbench for the PUSCH DR top level.
 * Drives LFSR-scaled beam samples over the RBG size codes, models
 * powers and ranking in queues and checks every output RE.
 */
`timescale 1ns/10ps

module tb_pusch_dr import dr_pkg::*; ();

    logic                     i_clk = 1'b0;
    logic                     i_reset, i_vld, i_sop, i_eop;
    logic [1:0]               i_rbg_size;
    sample_t [NUM_BEAM-1:0]   i_samples;
    logic                     o_dr_vld, o_dr_sop, o_dr_eop;
    logic [RBG_IDX_W-1:0]     o_rbg_idx;
    sample_t [NUM_PICK-1:0]   o_dr_data;
    beam_idx_t [NUM_PICK-1:0] o_beam_idx;
    pwr_t [NUM_PICK-1:0]      o_beam_pwr;

    logic [31:0]              lfsr = 32'hec11;
    sample_t [NUM_BEAM-1:0]   q_re [$];     // expected REs, input order
    pwr_t [NUM_BEAM-1:0]      q_pwr [$];    // per RBG: powers, length, index
    int                       q_len [$];
    int                       q_idx [$];
    int                       pick [NUM_PICK];
    pwr_t                     pick_pwr [NUM_PICK];
    int                       exp_len, exp_idx, out_cnt;
    bit                       seen_input;
    int                       errors, failures;

    always #20 i_clk = ~i_clk;

    pusch_dr_top #(.NUM_BEAM(NUM_BEAM), .NUM_PICK(NUM_PICK)) UUT (.*);

    bind pusch_dr_top pusch_dr_sva #(.NUM_PICK(NUM_PICK)) u_sva (
        .i_clk(i_clk), .i_reset(i_reset), .i_vld(i_vld), .i_pwr_vld(pwr_vld),
        .i_dr_vld(o_dr_vld), .i_dr_sop(o_dr_sop), .i_dr_eop(o_dr_eop),
        .i_beam_idx(o_beam_idx));

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [15:0] rand_comp(input int w);
        logic signed [31:0] v;
        v = $signed(rand_bits(w) << (32 - w)) >>> (32 - w);   // w-bit signed value
        return v[15:0];
    endfunction

    function automatic int size_to_len(input logic [1:0] code);
        return (code == 2'd0) ? 12 : ((code == 2'd1) ? 24 : 48);
    endfunction

    function automatic pwr_t sample_power(input sample_t s);
        longint i;
        longint q;
        i = $signed(s[31:16]);
        q = $signed(s[15:0]);
        return pwr_t'(i * i + q * q);
    endfunction

    task automatic value_error(input string what, input logic [63:0] got, input logic [63:0] exp);
        errors++;
        $display("** Error @ %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic rank_beams(input pwr_t [NUM_BEAM-1:0] p);
        bit taken [NUM_BEAM];
        int best;
        for (int k = 0; k < NUM_PICK; k++) begin
            best = -1;
            for (int b = 0; b < NUM_BEAM; b++) begin
                if (!taken[b] && (best < 0 || p[b] > p[best])) best = b;   // tie keeps lower
            end
            taken[best] = 1'b1;
            pick[k]     = best;
            pick_pwr[k] = p[best];
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic send_symbol(input logic [1:0] code, input int num_re, input bit tie);
        int len, pos, ridx;
        int w [NUM_BEAM];
        sample_t [NUM_BEAM-1:0] re;
        pwr_t [NUM_BEAM-1:0] acc;
        len  = size_to_len(code);
        pos  = 0;
        ridx = 0;
        for (int n = 0; n < num_re; n++) begin
            for (int b = 0; b < NUM_BEAM; b++) begin
                if (pos == 0) begin
                    w[b]   = 4 + int'(rand_bits(3));   // new scale per beam and RBG
                    acc[b] = '0;
                end
                if (tie && (b % 2 == 1)) re[b] = re[b-1];   // equal-power pairs
                else re[b] = {rand_comp(w[b]), rand_comp(w[b])};
                acc[b] = acc[b] + sample_power(re[b]);
            end
            @(posedge i_clk);
            i_vld      <= 1'b1;
            i_sop      <= (n == 0);
            i_eop      <= (n == num_re - 1);
            i_rbg_size <= code;
            i_samples  <= re;
            q_re.push_back(re);
            seen_input = 1'b1;
            if (pos == len - 1 || n == num_re - 1) begin   // RBG closes here
                q_pwr.push_back(acc);
                q_len.push_back(pos + 1);
                q_idx.push_back(ridx);
                pos = 0;
                ridx++;
            end else begin
                pos++;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge i_clk);
            i_vld <= 1'b0;
            i_sop <= 1'b0;
            i_eop <= 1'b0;
        end
    endtask

    task automatic drain_outputs();
        int cycles;
        idle_cycles(48);   // gap needed after a short last RBG
        cycles = 0;
        while (q_re.size() != 0 && cycles < 400) begin
            @(posedge i_clk);
            cycles++;
        end
        if (q_re.size() != 0) begin
            failures++;
            $display("Timeout: %0d expected output REs never came out", q_re.size());
            q_re.delete();
            q_pwr.delete();
            q_len.delete();
            q_idx.delete();
        end
    endtask

    // ------------------------------------------------------------------------
    // output checks, sampled mid-cycle
    // ------------------------------------------------------------------------
    task automatic check_out_re();
        sample_t [NUM_BEAM-1:0] re;
        if (o_dr_sop) begin
            if (q_len.size() == 0) begin
                failures++;
                $display("Output RBG started at %0t ns with no input RBG pending", $time);
                return;
            end
            rank_beams(q_pwr.pop_front());
            exp_len = q_len.pop_front();
            exp_idx = q_idx.pop_front();
            out_cnt = 0;
        end
        if (q_re.size() == 0) begin
            failures++;
            $display("Output RE at %0t ns with no input RE left to match", $time);
            return;
        end
        re = q_re.pop_front();
        assert (o_dr_sop == (out_cnt == 0)) else value_error("o_dr_sop", o_dr_sop, out_cnt == 0);
        assert (o_dr_eop == (out_cnt == exp_len - 1))
            else value_error("o_dr_eop", o_dr_eop, out_cnt == exp_len - 1);
        assert (o_rbg_idx == exp_idx) else value_error("o_rbg_idx", o_rbg_idx, exp_idx);
        for (int k = 0; k < NUM_PICK; k++) begin
            assert (o_beam_idx[k] == pick[k])
                else value_error($sformatf("o_beam_idx[%0d]", k), o_beam_idx[k], pick[k]);
            assert (o_beam_pwr[k] == pick_pwr[k])
                else value_error($sformatf("o_beam_pwr[%0d]", k), o_beam_pwr[k], pick_pwr[k]);
            assert (o_dr_data[k] == re[pick[k]])
                else value_error($sformatf("o_dr_data[%0d]", k), o_dr_data[k], re[pick[k]]);
            if (k > 0) begin
                assert (o_beam_pwr[k] <= o_beam_pwr[k-1])
                    else value_error("power order", o_beam_pwr[k], o_beam_pwr[k-1]);
            end
        end
        out_cnt++;
    endtask

    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (!seen_input) begin
                assert (!o_dr_vld && !o_dr_sop && !o_dr_eop)
                    else value_error("strobe before input", {o_dr_vld, o_dr_sop, o_dr_eop}, 0);
            end
            if (o_dr_vld) check_out_re();
        end
    end

    initial begin
        i_reset    = 1'b1;
        i_vld      = 1'b0;
        i_sop      = 1'b0;
        i_eop      = 1'b0;
        i_rbg_size = 2'd0;
        i_samples  = '0;
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
        idle_cycles(10);                 // outputs stay quiet
        send_symbol(2'd0, 48, 1'b0);     // four RBGs of 12
        drain_outputs();
        send_symbol(2'd1, 48, 1'b0);     // two RBGs of 24
        drain_outputs();
        send_symbol(2'd1, 12, 1'b0);     // one short RBG closed by i_eop
        drain_outputs();
        send_symbol(2'd2, 96, 1'b0);     // two symbols back to back
        send_symbol(2'd2, 96, 1'b0);
        drain_outputs();
        send_symbol(2'd0, 36, 1'b1);     // tie break toward lower index
        drain_outputs();
        $display("check errors: %0d, other failures: %0d", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
